// File: source/mul_pkg.sv
// Shared widths and state codes; step_count must equal data_width / digit_width
`default_nettype none

package mul_pkg;

    // Operand and result width, unsigned
    localparam int data_width = 32;

    // Fixed-point result is product[frac_bits+data_width-1:frac_bits]
    localparam int frac_bits = 8;

    // Multiplier bits consumed per step
    localparam int digit_width = 4;

    localparam int step_count = data_width / digit_width;

    // Must hold step_count - 1
    localparam int count_width = 4;

    localparam int cla_block_width = 4;

    // Control FSM encoding
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_calc   = 2'd1;
    localparam logic [1:0] st_finish = 2'd2;

endpackage

`default_nettype wire

// File: source/cla_block.sv
// Fixed 4-bit lookahead slice; carries are flattened two-level logic, no ripple inside
`default_nettype none

module cla_block (
    input  logic       carry_in,
    input  logic [3:0] a,
    input  logic [3:0] b,
    output logic [3:0] sum,
    output logic       carry_out
);

    logic [3:0] p;
    logic [3:0] g;
    logic [4:0] c;

    assign p = a ^ b;
    assign g = a & b;

    // Every carry straight from p, g and carry_in
    assign c[0] = carry_in;
    assign c[1] = g[0]
                | (p[0] & carry_in);
    assign c[2] = g[1]
                | (p[1] & g[0])
                | (p[1] & p[0] & carry_in);
    assign c[3] = g[2]
                | (p[2] & g[1])
                | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & carry_in);
    assign c[4] = g[3]
                | (p[3] & g[2])
                | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0])
                | (p[3] & p[2] & p[1] & p[0] & carry_in);

    assign sum       = p ^ c[3:0];
    assign carry_out = c[4];

endmodule

`default_nettype wire

// File: source/cla_adder.sv
// Unsigned adder, width must be a multiple of 4; carry ripples between blocks only
`default_nettype none

module cla_adder #(
    parameter int width = 32
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    output logic [width:0]   sum
);

    localparam int block_count = width / mul_pkg::cla_block_width;

    logic [block_count:0] carry;

    if (width % mul_pkg::cla_block_width != 0) begin : g_width_check
        $error("cla_adder width %0d is not a multiple of %0d",
               width, mul_pkg::cla_block_width);
    end

    assign carry[0] = 1'b0;

    for (genvar i = 0; i < block_count; i++) begin : g_block
        cla_block u_block (
            .carry_in  (carry[i]),
            .a         (a[i*mul_pkg::cla_block_width +: mul_pkg::cla_block_width]),
            .b         (b[i*mul_pkg::cla_block_width +: mul_pkg::cla_block_width]),
            .sum       (sum[i*mul_pkg::cla_block_width +: mul_pkg::cla_block_width]),
            .carry_out (carry[i+1])
        );
    end

    // Final carry becomes the top sum bit
    assign sum[width] = carry[block_count];

endmodule

`default_nettype wire

// File: source/partial_product_array.sv
// Combinational multiplicand x 4-bit digit; depth is three chained 32-bit lookahead adders
`default_nettype none

module partial_product_array (
    input  logic [mul_pkg::data_width-1:0]                      multiplicand,
    input  logic [mul_pkg::digit_width-1:0]                     digit,
    output logic [mul_pkg::data_width+mul_pkg::digit_width-1:0] partial
);

    logic [mul_pkg::data_width-1:0] row     [mul_pkg::digit_width];
    logic [mul_pkg::data_width:0]   run_sum [mul_pkg::digit_width];

    // Gated copies of the multiplicand, one per digit bit
    for (genvar i = 0; i < mul_pkg::digit_width; i++) begin : g_row
        assign row[i] = multiplicand & {mul_pkg::data_width{digit[i]}};
    end

    assign run_sum[0] = {1'b0, row[0]};

    // Each row adds onto the previous sum shifted down by one
    for (genvar i = 1; i < mul_pkg::digit_width; i++) begin : g_add
        cla_adder #(
            .width (mul_pkg::data_width)
        ) u_adder (
            .a   (row[i]),
            .b   (run_sum[i-1][mul_pkg::data_width:1]),
            .sum (run_sum[i])
        );
    end

    // Low bit that falls out of each row is final
    for (genvar i = 0; i < mul_pkg::digit_width; i++) begin : g_low
        assign partial[i] = run_sum[i][0];
    end

    assign partial[mul_pkg::data_width+mul_pkg::digit_width-1:mul_pkg::digit_width] =
        run_sum[mul_pkg::digit_width-1][mul_pkg::data_width:1];

endmodule

`default_nettype wire

// File: source/product_accumulator.sv
// Iterative datapath, one product at a time; y is truncated, upper product bits are dropped
`default_nettype none

module product_accumulator (
    input  logic                           ctl_clk,
    input  logic                           reset,
    input  logic [mul_pkg::data_width-1:0] a,
    input  logic [mul_pkg::data_width-1:0] b,
    input  logic                           load,
    input  logic                           step,
    input  logic                           finish,
    output logic [mul_pkg::data_width-1:0] y
);

    logic [mul_pkg::data_width-1:0]                      a_reg;
    logic [mul_pkg::data_width-1:0]                      b_reg;
    logic [2*mul_pkg::data_width-1:0]                    product;
    logic [mul_pkg::data_width+mul_pkg::digit_width-1:0] partial;
    logic [mul_pkg::data_width+mul_pkg::digit_width:0]   acc_sum;

    partial_product_array u_partial (
        .multiplicand (a_reg),
        .digit        (b_reg[mul_pkg::digit_width-1:0]),
        .partial      (partial)
    );

    // Upper half plus this step's partial product
    cla_adder #(
        .width (mul_pkg::data_width + mul_pkg::digit_width)
    ) u_acc_adder (
        .a   (partial),
        .b   ({{mul_pkg::digit_width{1'b0}},
               product[2*mul_pkg::data_width-1:mul_pkg::data_width]}),
        .sum (acc_sum)
    );

    always_ff @(posedge ctl_clk) begin
        if (load) begin
            a_reg   <= a;
            b_reg   <= b;
            product <= '0;
        end else if (step) begin
            // Sum goes to the top, low half moves down one digit
            product <= {acc_sum[mul_pkg::data_width+mul_pkg::digit_width-1:0],
                        product[mul_pkg::data_width-1:mul_pkg::digit_width]};
            b_reg   <= b_reg >> mul_pkg::digit_width;
        end
    end

    // Fixed-point slice of the finished product
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            y <= '0;
        end else if (finish) begin
            y <= product[mul_pkg::frac_bits+mul_pkg::data_width-1:mul_pkg::frac_bits];
        end
    end

    a_load_step_exclusive: assert property (
        @(posedge ctl_clk) disable iff (!reset)
        !(load && step)
    ) else $error("load and step asserted together");

endmodule

`default_nettype wire

// File: source/mul_control.sv
// Fixed 9-cycle sequence per operation; trigger is ignored unless ready is high
`default_nettype none

module mul_control (
    input  logic ctl_clk,
    input  logic reset,
    input  logic trigger,
    output logic ready,
    output logic done,
    output logic load,
    output logic step,
    output logic finish
);

    logic [1:0]                      state;
    logic [mul_pkg::count_width-1:0] count;

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state <= mul_pkg::st_idle;
            count <= '0;
        end else begin
            case (state)
                mul_pkg::st_idle: begin
                    count <= '0;
                    if (trigger) begin
                        state <= mul_pkg::st_calc;
                    end
                end
                mul_pkg::st_calc: begin
                    count <= count + 1'b1;
                    // Last digit consumed at this edge
                    if (count == mul_pkg::count_width'(mul_pkg::step_count - 1)) begin
                        state <= mul_pkg::st_finish;
                    end
                end
                mul_pkg::st_finish: begin
                    state <= mul_pkg::st_idle;
                end
                default: begin
                    state <= mul_pkg::st_idle;
                end
            endcase
        end
    end

    assign ready  = (state == mul_pkg::st_idle);
    assign load   = ready && trigger;
    assign step   = (state == mul_pkg::st_calc);
    assign finish = (state == mul_pkg::st_finish);

    // Lines up with the y update
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            done <= 1'b0;
        end else begin
            done <= finish;
        end
    end

    a_done_single: assert property (
        @(posedge ctl_clk) disable iff (!reset)
        done |=> !done
    ) else $error("done held for more than one cycle");

    a_ready_not_step: assert property (
        @(posedge ctl_clk) disable iff (!reset)
        !(ready && step)
    ) else $error("ready high during a calculation step");

    // done rises at the ninth edge after acceptance, seen at the tenth sample
    a_done_latency: assert property (
        @(posedge ctl_clk) disable iff (!reset)
        load |=> !done [*9] ##1 done
    ) else $error("done did not follow the accepted trigger by 9 cycles");

endmodule

`default_nettype wire

// File: source/hybrid_multiplier.sv
// Unsigned 32x32 fixed-point multiply returning product bits 39:8, no rounding or saturation
`default_nettype none

module hybrid_multiplier (
    input  logic                           ctl_clk,
    input  logic                           reset,
    input  logic [mul_pkg::data_width-1:0] a,
    input  logic [mul_pkg::data_width-1:0] b,
    input  logic                           trigger,
    output logic                           ready,
    output logic                           done,
    output logic [mul_pkg::data_width-1:0] y
);

    logic load;
    logic step;
    logic finish;

    // Sequencing only
    mul_control u_control (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .load    (load),
        .step    (step),
        .finish  (finish)
    );

    // Operands, accumulator and result register
    product_accumulator u_datapath (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .load    (load),
        .step    (step),
        .finish  (finish),
        .y       (y)
    );

endmodule

`default_nettype wire

// File: tb/tb_hybrid_multiplier.sv
// Inputs change on the falling edge only; every wait gives up after 50 clock cycles
`default_nettype none

module tb_hybrid_multiplier;

    localparam int timeout_cycles = 50;
    localparam int latency_cycles = 9;
    localparam int random_ops     = 200;

    logic                           ctl_clk;
    logic                           reset;
    logic [mul_pkg::data_width-1:0] a;
    logic [mul_pkg::data_width-1:0] b;
    logic                           trigger;
    logic                           ready;
    logic                           done;
    logic [mul_pkg::data_width-1:0] y;

    // Result the DUT must keep showing until its next done
    logic [mul_pkg::data_width-1:0] last_y;

    hybrid_multiplier dut0 (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .y       (y)
    );

    initial begin
        ctl_clk = 1'b0;
    end

    always #20 ctl_clk = ~ctl_clk;

    // Full unsigned product, fixed-point slice above the fraction bits
    function automatic logic [mul_pkg::data_width-1:0] model_slice(
        input logic [mul_pkg::data_width-1:0] op_a,
        input logic [mul_pkg::data_width-1:0] op_b
    );
        logic [2*mul_pkg::data_width-1:0] wide_a;
        logic [2*mul_pkg::data_width-1:0] wide_b;
        logic [2*mul_pkg::data_width-1:0] full;
        wide_a = op_a;
        wide_b = op_b;
        full   = wide_a * wide_b;
        return full[mul_pkg::frac_bits +: mul_pkg::data_width];
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(
        input string                          name,
        input logic [mul_pkg::data_width-1:0] got,
        input logic [mul_pkg::data_width-1:0] expected
    );
        if (got !== expected) begin
            stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic wait_for_ready();
        int waited;
        waited = 0;
        while (ready !== 1'b1) begin
            if (waited >= timeout_cycles) begin
                stop_run("Timed out waiting for ready to rise");
            end
            @(negedge ctl_clk);
            waited++;
        end
    endtask

    // One multiply; disturb_cycle 1..9 puts an ignored trigger at that edge after acceptance
    task automatic run_op(
        input logic [mul_pkg::data_width-1:0] op_a,
        input logic [mul_pkg::data_width-1:0] op_b,
        input int                             disturb_cycle
    );
        logic [mul_pkg::data_width-1:0] expected;
        int                             cycles;
        expected = model_slice(op_a, op_b);
        wait_for_ready();
        a       = op_a;
        b       = op_b;
        trigger = 1'b1;
        @(negedge ctl_clk);
        // Operands are free to change after acceptance
        trigger = 1'b0;
        a       = $urandom;
        b       = $urandom;
        cycles  = 0;
        while (done !== 1'b1) begin
            if (cycles >= timeout_cycles) begin
                stop_run("Timed out waiting for done after an accepted trigger");
            end
            check_bit("ready", ready, 1'b0);
            check_word("y", y, last_y);
            trigger = (cycles + 1 == disturb_cycle);
            if (cycles + 1 == disturb_cycle) begin
                a = ~op_a;
                b = $urandom;
            end
            @(negedge ctl_clk);
            cycles++;
        end
        trigger = 1'b0;
        if (cycles != latency_cycles) begin
            stop_run($sformatf("done came %0d cycles after the accepted trigger instead of %0d",
                               cycles, latency_cycles));
        end
        check_bit("ready", ready, 1'b1);
        check_word("y", y, expected);
        @(negedge ctl_clk);
        check_bit("done", done, 1'b0);
        check_word("y", y, expected);
        last_y = expected;
    endtask

    // No trigger, operands wander, y must stay put
    task automatic hold_idle(input int idle_cycles);
        repeat (idle_cycles) begin
            trigger = 1'b0;
            a       = $urandom;
            b       = $urandom;
            @(negedge ctl_clk);
            check_bit("done", done, 1'b0);
            check_bit("ready", ready, 1'b1);
            check_word("y", y, last_y);
        end
    endtask

    initial begin
        logic [mul_pkg::data_width-1:0] value;
        logic [mul_pkg::data_width-1:0] one_fixed;
        logic [mul_pkg::data_width-1:0] power_a;
        logic [mul_pkg::data_width-1:0] power_b;
        int                             disturb;
        void'($urandom(64));
        reset       = 1'b0;
        trigger     = 1'b0;
        a           = '0;
        b           = '0;
        last_y      = '0;
        one_fixed   = '0;
        one_fixed[mul_pkg::frac_bits] = 1'b1;

        repeat (4) @(negedge ctl_clk);
        reset = 1'b1;
        @(negedge ctl_clk);
        check_bit("done", done, 1'b0);
        check_bit("ready", ready, 1'b1);
        check_word("y", y, '0);

        // Corner operands
        run_op('0, '0, 0);
        run_op('0, '1, 0);
        run_op('1, '0, 0);
        run_op('1, '1, 0);
        run_op('1, 32'd1, 0);
        run_op(32'd1, '1, 0);
        hold_idle(4);
        for (int i = 0; i < mul_pkg::data_width; i += 3) begin
            power_a = '0;
            power_b = '0;
            power_a[i] = 1'b1;
            power_b[(i * 7) % mul_pkg::data_width] = 1'b1;
            run_op(power_a, power_b, 0);
        end
        value = $urandom;
        run_op(one_fixed, value, 0);
        check_word("y", y, value);
        value = $urandom;
        run_op(value, one_fixed, 0);
        check_word("y", y, value);

        // Ignored trigger at every edge while the operation runs
        for (int c = 1; c <= latency_cycles; c++) begin
            run_op($urandom, $urandom, c);
        end

        for (int n = 0; n < random_ops; n++) begin
            disturb = ($urandom % 3 == 0) ? 1 + ($urandom % latency_cycles) : 0;
            run_op($urandom, $urandom, disturb);
            if (n % 40 == 0) begin
                hold_idle(3 + ($urandom % 5));
            end
        end
        hold_idle(6);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/mul_pkg.sv
source/cla_block.sv
source/cla_adder.sv
source/partial_product_array.sv
source/product_accumulator.sv
source/mul_control.sv
source/hybrid_multiplier.sv
tb/tb_hybrid_multiplier.sv
